// File: mandelRender.f
+incdir+verilog
verilog/mandelPkg.sv
verilog/coordGenerator.sv
verilog/renderTimer.sv
verilog/loadBalancer.sv
verilog/mandelProcessor.sv
verilog/procMemArb.sv
verilog/mandelRender.sv
tb/tb_mandelRender.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the testbench and the DUT with Verilator, run the simulation,
# and decide pass or fail from the simulation's own result line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f mandelRender.f \
  --top-module tb_mandelRender -o simMandel \
  || { echo "Verilator build failed"; exit 1; }

simOut="$(./obj_dir/simMandel)"
echo "$simOut"

echo "$simOut" | grep -q "Result: PASSED" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

// File: tb/render_cases.txt
// cornerX cornerY zoom addr0 addr1 addr2 addr3 color0 color1 color2 color3 allInside
// Coordinates are 4.32 fixed point in 36 bits; one case per line
// Case 0: corner (-2, 1.5), zoom 0; probes c=1, c=0.5, c=1.5i, c=0
E00000000 180000000 0 6C 6A 08 68 4 6 3 0 0
// Case 1: corner (-0.125, 0.0625), zoom 5; whole frame inside the set
FE0000000 010000000 5 00 5F A3 BF 0 0 0 0 1
// Case 2: corner (-1.5, 1), zoom 1; probes (-1.5,1), 0.375, (-1.5,-0.375), (-0.25,0.25)
E80000000 100000000 1 00 8F B0 6A 3 1 5 0 0
// Case 3: corner (-2, 1.5), zoom 0 again; probes (0.5,0.5), (1.75,-1.25), -2, (-2,1.5)
E00000000 180000000 0 4A BF 60 00 6 2 0 2 0

// File: tb/tb_mandelRender.sv
`timescale 1ns/1ps
`include "mandel_settings.svh"

module tb_mandelRender import mandelPkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int MS_CYCLES = 100;  // Short prescaler for simulation
  localparam int FRAME_PIX = `FRAME_W * `FRAME_H;
  localparam int NUM_CASES = 4;
  localparam int WORDS = 12;       // Columns per line of the cases file
  localparam int WATCH_CYCLES = NUM_CASES * FRAME_PIX * (`MAX_ITER + 4) + 40;

  logic CLOCK_50;
  logic reset;
  logic start;
  logic signed [`FIX_W-1:0] upperLeftX;
  logic signed [`FIX_W-1:0] upperLeftY;
  logic [`ZOOM_W-1:0] zoom;
  logic pixWrEn;
  pixelWrite_t pixWrite;
  logic done;
  logic [15:0] renderMs;

  logic [`FIX_W-1:0] cases [NUM_CASES * WORDS];
  logic [`COLOR_W-1:0] image [256];  // Frame buffer model
  int writeHits [256];               // Writes seen per address
  int frameWrites;
  int testsRun;
  int testsFailed;
  int errors;

  mandelRender #(.cyclesPerMs(MS_CYCLES)) u_mandelRender (
    .CLOCK_50, .reset, .start, .upperLeftX, .upperLeftY, .zoom,
    .pixWrEn, .pixWrite, .done, .renderMs
  );

  initial begin
    CLOCK_50 = 1'b0;
    forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
  end

  // Watchdog sized from the worst case of every pixel at the limit
  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("Timeout: frames not finished within %0d cycles", WATCH_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Frame buffer model sampled mid cycle
  ////////////////////////////////////////
  always @(negedge CLOCK_50) begin
    if (start) begin  // New frame clears the old image
      for (int a = 0; a < 256; a++) begin
        image[a] = '1;  // Sentinel 7 marks unwritten
        writeHits[a] = 0;
      end
      frameWrites = 0;
    end else if (!reset && pixWrEn === 1'b1) begin
      image[pixWrite.addr] = pixWrite.color;
      writeHits[pixWrite.addr]++;
      frameWrites++;
    end
  end

  task automatic finishTest(input string name, input int bad);
    testsRun++;
    errors += bad;
    if (bad != 0) testsFailed++;
    $display("Test %s: %s, %0d errors", name, (bad == 0) ? "ok" : "bad", bad);
  endtask

  // Outputs must stay quiet between reset and the first start
  task automatic checkIdle();
    int bad;
    bad = 0;
    repeat (10) begin
      @(negedge CLOCK_50);
      if (pixWrEn !== 1'b0) begin
        $display("** Error: pixWrEn got %h, expected 0", pixWrEn);
        bad++;
      end
      if (done !== 1'b0) begin
        $display("** Error: done got %h, expected 0", done);
        bad++;
      end
      if (renderMs !== 16'h0) begin
        $display("** Error: renderMs got %h, expected 0000", renderMs);
        bad++;
      end
    end
    finishTest("idle after reset", bad);
  endtask

  ////////////////////////////////////////
  // One frame from the cases file
  ////////////////////////////////////////
  task automatic runCase(input int c);
    int base;
    int bad;
    int elapsed;
    int wantMs;
    logic [`ADDR_W-1:0] addr;
    logic [`COLOR_W-1:0] want;
    logic prevWrite;
    logic [15:0] msAtDone;
    base = c * WORDS;
    bad = 0;
    @(posedge CLOCK_50);
    #2;
    upperLeftX = cases[base];
    upperLeftY = cases[base + 1];
    zoom = cases[base + 2][`ZOOM_W-1:0];
    start = 1'b1;
    @(posedge CLOCK_50);  // DUT takes start here
    #2;
    start = 1'b0;
    if (done !== 1'b0) begin  // Restart clears done
      $display("** Error: done got %h, expected 0", done);
      bad++;
    end
    if (renderMs !== 16'h0) begin
      $display("** Error: renderMs got %h, expected 0000", renderMs);
      bad++;
    end
    elapsed = 0;  // Cycles from start to done
    prevWrite = 1'b0;
    @(negedge CLOCK_50);
    while (done !== 1'b1) begin
      elapsed++;
      prevWrite = (pixWrEn === 1'b1);  // Last cycle before done must write
      @(negedge CLOCK_50);
    end
    if (!prevWrite) begin
      $display("done did not rise on the cycle after the last write");
      bad++;
    end
    if (frameWrites != FRAME_PIX) begin
      $display("Frame wrote %0d pixels before done, expected %0d", frameWrites, FRAME_PIX);
      bad++;
    end
    for (int a = 0; a < 256; a++) begin
      if (writeHits[a] != ((a < FRAME_PIX) ? 1 : 0)) begin
        $display("Address %h written %0d times in this frame", a, writeHits[a]);
        bad++;
      end
    end
    for (int p = 0; p < 4; p++) begin  // Probe pixels
      addr = cases[base + 3 + p][`ADDR_W-1:0];
      want = cases[base + 7 + p][`COLOR_W-1:0];
      if (image[addr] !== want) begin
        $display("** Error: pixWrite.color at %h got %h, expected %h", addr, image[addr], want);
        bad++;
      end
    end
    if (cases[base + 11][0]) begin  // Whole frame inside the set
      for (int a = 0; a < FRAME_PIX; a++) begin
        if (image[a] !== '0) begin
          $display("** Error: pixWrite.color at %h got %h, expected 0", a, image[a]);
          bad++;
        end
      end
    end
    wantMs = elapsed / MS_CYCLES;
    if (int'(renderMs) > wantMs + 1 || int'(renderMs) + 1 < wantMs) begin
      $display("** Error: renderMs got %h, expected %h", renderMs, wantMs[15:0]);
      bad++;
    end
    // Finished frame holds done and the timer
    msAtDone = renderMs;
    repeat (MS_CYCLES + 10) begin  // Longer than one timer tick
      @(negedge CLOCK_50);
      if (done !== 1'b1) begin
        $display("** Error: done got %h, expected 1", done);
        bad++;
      end
      if (pixWrEn !== 1'b0) begin
        $display("** Error: pixWrEn got %h, expected 0", pixWrEn);
        bad++;
      end
      if (renderMs !== msAtDone) begin
        $display("** Error: renderMs got %h, expected %h", renderMs, msAtDone);
        bad++;
      end
    end
    $display("Frame %0d took %0d cycles, timer %0d ms", c, elapsed, renderMs);
    finishTest($sformatf("case %0d", c), bad);
  endtask

  initial begin
    reset = 1'b1;
    start = 1'b0;
    upperLeftX = '0;
    upperLeftY = '0;
    zoom = '0;
    testsRun = 0;
    testsFailed = 0;
    errors = 0;
    frameWrites = 0;
    $readmemh("tb/render_cases.txt", cases);
    repeat (8) @(posedge CLOCK_50);
    #2;
    reset = 1'b0;
    checkIdle();
    for (int c = 0; c < NUM_CASES; c++) begin
      runCase(c);  // Every case after the first is a restart
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/coordGenerator.sv
`timescale 1ns/1ps
`include "mandel_settings.svh"

module coordGenerator import mandelPkg::*; (
  input  logic                     CLOCK_50,
  input  logic                     reset,
  input  logic                     start,       // Begin a new frame
  input  logic signed [`FIX_W-1:0] upperLeftX,
  input  logic signed [`FIX_W-1:0] upperLeftY,
  input  logic [`ZOOM_W-1:0]       zoom,
  input  logic                     taskRdy,     // Some processor is idle
  input  logic                     pixWrEn,     // Copy of the write strobe
  output logic                     taskVal,
  output coordTask_t               taskData,
  output logic                     busy,
  output logic                     done
);

  localparam int FRAME_PIX = `FRAME_W * `FRAME_H;
  localparam int CNT_W = $clog2(FRAME_PIX + 1);
  localparam int COL_W = $clog2(`FRAME_W);
  localparam int ROW_W = $clog2(`FRAME_H);

  genState_t state;
  logic signed [`FIX_W-1:0] cornerX;  // Left edge reloaded at each row
  logic signed [`FIX_W-1:0] step;
  logic signed [`FIX_W-1:0] curX;
  logic signed [`FIX_W-1:0] curY;
  logic [COL_W-1:0] col;
  logic [ROW_W-1:0] row;
  logic [`ADDR_W-1:0] addrCnt;
  logic [CNT_W-1:0] writeCount;  // Pixels already written back
  logic taskFire;
  logic lastCol;
  logic lastRow;
  logic startOk;

  assign taskVal  = (state == GEN_ISSUE);
  assign taskData = '{cx: curX, cy: curY, pixAddr: addrCnt};
  assign busy     = (state == GEN_ISSUE) || (state == GEN_DRAIN);
  assign done     = (state == GEN_DONE);

  assign taskFire = taskVal && taskRdy;
  assign lastCol  = (col == COL_W'(`FRAME_W - 1));
  assign lastRow  = (row == ROW_W'(`FRAME_H - 1));
  assign startOk  = start && ((state == GEN_IDLE) || (state == GEN_DONE));

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////
  always_ff @(posedge CLOCK_50) begin
    if (reset) begin
      state <= GEN_IDLE;
    end else begin
      case (state)
        GEN_IDLE, GEN_DONE: if (start) state <= GEN_ISSUE;
        GEN_ISSUE: if (taskFire && lastCol && lastRow) state <= GEN_DRAIN;
        // Done on the cycle after the final write
        GEN_DRAIN: if (pixWrEn && writeCount == CNT_W'(FRAME_PIX - 1)) state <= GEN_DONE;
        default: state <= GEN_IDLE;
      endcase
    end
  end

  // Raster walk by addition without a multiplier
  always_ff @(posedge CLOCK_50) begin
    if (startOk) begin
      cornerX    <= upperLeftX;
      step       <= `BASE_STEP >> zoom;  // Halves per zoom level
      curX       <= upperLeftX;
      curY       <= upperLeftY;
      col        <= '0;
      row        <= '0;
      addrCnt    <= '0;
      writeCount <= '0;
    end else begin
      if (taskFire) begin
        addrCnt <= addrCnt + 1'b1;
        if (lastCol) begin
          col  <= '0;
          row  <= row + 1'b1;
          curX <= cornerX;     // Back to left edge
          curY <= curY - step; // Rows go downward
        end else begin
          col  <= col + 1'b1;
          curX <= curX + step;
        end
      end
      if (pixWrEn) writeCount <= writeCount + 1'b1;
    end
  end

endmodule

// File: verilog/loadBalancer.sv
`timescale 1ns/1ps
`include "mandel_settings.svh"

module loadBalancer import mandelPkg::*; (
  input  logic                  taskVal,
  input  coordTask_t            taskData,
  input  logic [`NUM_PROCS-1:0] procIdle,  // One bit per processor
  output logic                  taskRdy,
  output logic [`NUM_PROCS-1:0] procLoad,  // One-hot load strobe
  output coordTask_t            procTask   // Shared by all processors
);

  ////////////////////////////////////////
  // Lowest index idle processor wins
  ////////////////////////////////////////
  always_comb begin
    logic found;
    found    = 1'b0;
    procLoad = '0;
    for (int i = 0; i < `NUM_PROCS; i++) begin
      if (taskVal && procIdle[i] && !found) begin
        procLoad[i] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  assign taskRdy  = |procIdle;  // Stall only when the whole pool is busy
  assign procTask = taskData;   // Only the strobed processor latches it

  // At most one load, and never into a busy processor
  always_comb begin
    assert ($onehot0(procLoad) && ((procLoad & ~procIdle) == '0))
      else $error("bad load vector %b idle %b", procLoad, procIdle);
  end

endmodule

// File: verilog/mandelPkg.sv
`include "mandel_settings.svh"

package mandelPkg;

  ////////////////////////////////////////
  // Payload structs
  ////////////////////////////////////////

  // One pixel of work, generator to processors
  typedef struct packed {
    logic signed [`FIX_W-1:0] cx;  // Real part of c
    logic signed [`FIX_W-1:0] cy;  // Imaginary part of c
    logic [`ADDR_W-1:0] pixAddr;
  } coordTask_t;

  // Finished pixel, processors to frame buffer
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`COLOR_W-1:0] color;
  } pixelWrite_t;

  ////////////////////////////////////////
  // State machines
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    GEN_IDLE,   // Waiting for start
    GEN_ISSUE,  // Walking the frame
    GEN_DRAIN,  // All tasks out, waiting on writes
    GEN_DONE    // Frame complete
  } genState_t;

  typedef enum logic [1:0] {
    PROC_IDLE,
    PROC_ITER,  // One update per cycle
    PROC_HOLD   // Result waiting for the arbiter
  } procState_t;

endpackage

// File: verilog/mandelProcessor.sv
`timescale 1ns/1ps
`include "mandel_settings.svh"

module mandelProcessor import mandelPkg::*; #(
  parameter int maxIter = `MAX_ITER
) (
  input  logic        CLOCK_50,
  input  logic        reset,
  input  logic        load,      // From the balancer
  input  coordTask_t  loadTask,
  input  logic        resAck,    // Arbiter took the result
  output logic        idle,
  output logic        resVal,
  output pixelWrite_t res
);

  localparam int ITER_W = $clog2(maxIter + 1);
  localparam int PROD_W = 2 * `FIX_W;
  localparam int SQ_W = PROD_W - `FRAC_W + 1;  // Room for |z|^2 after a large update
  localparam logic [SQ_W-1:0] ESC_LIMIT = SQ_W'(4) << `FRAC_W;

  procState_t state;
  logic signed [`FIX_W-1:0] zr;
  logic signed [`FIX_W-1:0] zi;
  logic signed [`FIX_W-1:0] cr;
  logic signed [`FIX_W-1:0] ci;
  logic [`ADDR_W-1:0] pixAddr;
  logic [`COLOR_W-1:0] color;
  logic [ITER_W-1:0] iterCount;  // Updates applied so far

  logic signed [PROD_W-1:0] zrSqFull;
  logic signed [PROD_W-1:0] ziSqFull;
  logic signed [PROD_W-1:0] crossFull;
  logic [SQ_W-1:0] magSq;
  logic [`FIX_W-1:0] nextZr;
  logic [`FIX_W-1:0] nextZi;
  logic escape;
  logic atLimit;

  ////////////////////////////////////////
  // Datapath with three multipliers
  ////////////////////////////////////////
  assign zrSqFull  = zr * zr;
  assign ziSqFull  = zi * zi;
  assign crossFull = zr * zi;

  // Squares are never negative so the extra integer bits stay
  assign magSq = {1'b0, zrSqFull[PROD_W-1:`FRAC_W]} + {1'b0, ziSqFull[PROD_W-1:`FRAC_W]};
  assign escape  = (magSq > ESC_LIMIT);
  assign atLimit = (iterCount == ITER_W'(maxIter));

  // z^2 + c back in 4.32
  assign nextZr = zrSqFull[`FIX_W+`FRAC_W-1:`FRAC_W] - ziSqFull[`FIX_W+`FRAC_W-1:`FRAC_W] + cr;
  assign nextZi = crossFull[`FIX_W+`FRAC_W-2:`FRAC_W-1] + ci;  // 2*zr*zi by index shift

  assign idle   = (state == PROC_IDLE);
  assign resVal = (state == PROC_HOLD);
  assign res    = '{addr: pixAddr, color: color};

  always_ff @(posedge CLOCK_50) begin
    if (reset) begin
      state <= PROC_IDLE;
    end else begin
      case (state)
        PROC_IDLE: if (load) state <= PROC_ITER;
        PROC_ITER: if (atLimit || escape) state <= PROC_HOLD;
        PROC_HOLD: if (resAck) state <= PROC_IDLE;
        default:   state <= PROC_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLOCK_50) begin
    case (state)
      PROC_IDLE: begin
        if (load) begin
          zr        <= '0;  // z starts at the origin
          zi        <= '0;
          cr        <= loadTask.cx;
          ci        <= loadTask.cy;
          pixAddr   <= loadTask.pixAddr;
          iterCount <= '0;
        end
      end
      PROC_ITER: begin
        if (atLimit) begin
          color <= '0;  // Inside the set
        end else if (escape) begin
          color <= `COLOR_W'(iterCount % 7 + 1);
        end else begin
          zr        <= nextZr;
          zi        <= nextZi;
          iterCount <= iterCount + 1'b1;
        end
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // Handshake checks
  ////////////////////////////////////////
  assert property (@(posedge CLOCK_50) disable iff (reset) load |-> state == PROC_IDLE)
    else $error("load while processor busy");

  assert property (@(posedge CLOCK_50) disable iff (reset) resAck |-> state == PROC_HOLD)
    else $error("ack without a result");

endmodule

// File: verilog/mandelRender.sv
`timescale 1ns/1ps
`include "mandel_settings.svh"

module mandelRender import mandelPkg::*; #(
  parameter int cyclesPerMs = `CYCLES_PER_MS
) (
  input  logic                     CLOCK_50,
  input  logic                     reset,
  input  logic                     start,
  input  logic signed [`FIX_W-1:0] upperLeftX,
  input  logic signed [`FIX_W-1:0] upperLeftY,
  input  logic [`ZOOM_W-1:0]       zoom,
  output logic                     pixWrEn,    // Frame buffer write strobe
  output pixelWrite_t              pixWrite,
  output logic                     done,
  output logic [15:0]              renderMs
);

  // Generator to balancer
  logic taskVal;
  logic taskRdy;
  logic busy;
  coordTask_t genTask;

  // Balancer and arbiter to the pool
  logic [`NUM_PROCS-1:0] procIdle;
  logic [`NUM_PROCS-1:0] procLoad;
  coordTask_t procTask;
  logic [`NUM_PROCS-1:0] resVal;
  logic [`NUM_PROCS-1:0] resAck;
  pixelWrite_t procRes [`NUM_PROCS];

  coordGenerator u_coordGenerator (
    .CLOCK_50, .reset, .start, .upperLeftX, .upperLeftY, .zoom,
    .taskRdy, .pixWrEn, .taskVal, .taskData(genTask), .busy, .done
  );

  renderTimer #(.cyclesPerMs(cyclesPerMs)) u_renderTimer (
    .CLOCK_50, .reset, .start, .busy, .renderMs
  );

  loadBalancer u_loadBalancer (
    .taskVal, .taskData(genTask), .procIdle, .taskRdy, .procLoad, .procTask
  );

  ////////////////////////////////////////
  // Processor pool
  ////////////////////////////////////////
  for (genvar i = 0; i < `NUM_PROCS; i++) begin : g_proc
    mandelProcessor #(.maxIter(`MAX_ITER)) u_mandelProcessor (
      .CLOCK_50, .reset,
      .load(procLoad[i]), .loadTask(procTask),
      .resAck(resAck[i]), .idle(procIdle[i]),
      .resVal(resVal[i]), .res(procRes[i])
    );
  end

  procMemArb u_procMemArb (
    .CLOCK_50, .reset, .resVal, .res(procRes), .resAck, .pixWrEn, .pixWrite
  );

endmodule

// File: verilog/mandel_settings.svh
`ifndef MANDEL_SETTINGS_SVH
`define MANDEL_SETTINGS_SVH

// Fixed point coordinates, 4 integer bits incl sign
`define FIX_W 36
`define FRAC_W 32

// Frame geometry, address is row * FRAME_W + col
`define FRAME_W 16
`define FRAME_H 12
`define ADDR_W 8

`define NUM_PROCS 4   // Iterating processors in the pool
`define MAX_ITER 100  // Points reaching this count are inside the set

`define BASE_STEP 36'h0_4000_0000  // 1/4 at zoom 0

`define CYCLES_PER_MS 50000  // 1 ms at 50 MHz

`define COLOR_W 3
`define ZOOM_W 4

`endif

// File: verilog/procMemArb.sv
`timescale 1ns/1ps
`include "mandel_settings.svh"

module procMemArb import mandelPkg::*; (
  input  logic                  CLOCK_50,
  input  logic                  reset,
  input  logic [`NUM_PROCS-1:0] resVal,              // Results waiting
  input  pixelWrite_t           res [`NUM_PROCS],
  output logic [`NUM_PROCS-1:0] resAck,              // One-hot grant
  output logic                  pixWrEn,
  output pixelWrite_t           pixWrite
);

  localparam int PTR_W = $clog2(`NUM_PROCS);

  logic [PTR_W-1:0] lastPtr;   // Most recent grant
  logic [PTR_W-1:0] grantIdx;
  logic found;

  ////////////////////////////////////////
  // Round robin, search starts after lastPtr
  ////////////////////////////////////////
  always_comb begin
    int idx;
    idx      = 0;
    found    = 1'b0;
    grantIdx = lastPtr;
    for (int k = 1; k <= `NUM_PROCS; k++) begin
      idx = (int'(lastPtr) + k) % `NUM_PROCS;
      if (!found && resVal[idx]) begin
        found    = 1'b1;
        grantIdx = PTR_W'(idx);
      end
    end
    resAck           = '0;
    resAck[grantIdx] = found;
  end

  // Write leaves in the same cycle as the ack
  assign pixWrEn  = found;
  assign pixWrite = res[grantIdx];

  always_ff @(posedge CLOCK_50) begin
    if (reset) begin
      lastPtr <= PTR_W'(`NUM_PROCS - 1);  // Processor 0 first
    end else if (found) begin
      lastPtr <= grantIdx;
    end
  end

  assert property (@(posedge CLOCK_50) disable iff (reset) $onehot0(resAck))
    else $error("multiple grants %b", resAck);

endmodule

// File: verilog/renderTimer.sv
`timescale 1ns/1ps
`include "mandel_settings.svh"

module renderTimer #(
  parameter int cyclesPerMs = `CYCLES_PER_MS
) (
  input  logic        CLOCK_50,
  input  logic        reset,
  input  logic        start,     // Clears the elapsed time
  input  logic        busy,      // Frame in progress
  output logic [15:0] renderMs
);

  localparam int PRE_W = $clog2(cyclesPerMs);

  logic [PRE_W-1:0] prescale;  // Cycles within the current ms
  logic msTick;

  assign msTick = (prescale == PRE_W'(cyclesPerMs - 1));

  always_ff @(posedge CLOCK_50) begin
    if (reset || start) begin
      prescale <= '0;
      renderMs <= '0;
    end else if (busy) begin
      if (msTick) begin
        prescale <= '0;
        renderMs <= renderMs + 1'b1;
      end else begin
        prescale <= prescale + 1'b1;
      end
    end
    // Not busy, hold the count
  end

endmodule
